// File: verilog/iq_pkg.sv
package iq_pkg;

    // register value width
    parameter int xlen = 32;

    // physical register file
    parameter int phys_reg_bits = 6;
    parameter int num_phys_regs = 1 << phys_reg_bits;

    // reorder buffer index width
    parameter int rob_bits = 6;

    // functional unit id, limits the queue to four units
    parameter int unit_bits = 2;

    typedef logic [phys_reg_bits-1:0] phys_reg_t;
    typedef logic [unit_bits-1:0]     unit_id_t;

    // renamed instruction from the register read stage
    typedef struct packed {
        logic [2:0]          funct3;
        logic [6:0]          funct7;
        logic [6:0]          opcode;
        phys_reg_t           rd;
        phys_reg_t           rs1;
        logic [xlen-1:0]     rs1_val;
        phys_reg_t           rs2;
        logic [xlen-1:0]     rs2_val;
        logic [xlen-1:0]     immediate;
        logic [rob_bits-1:0] rob_index;
    } dispatch_t;

    // one queue slot, also the payload on an issue port
    typedef struct packed {
        dispatch_t inst;
        unit_id_t  unit;
    } iq_entry_t;

    // result bus of one functional unit
    typedef struct packed {
        logic            valid;
        phys_reg_t       tag;
        logic [xlen-1:0] value;
    } fu_result_t;

endpackage

// File: verilog/reg_scoreboard.sv
`timescale 1ns/1ps

module reg_scoreboard import iq_pkg::*; #(
    parameter int num_units = 3
) (
    input  logic       clk,
    input  logic       reset_n,
    input  logic       dispatch_accept,
    input  phys_reg_t  dispatch_rd,
    input  phys_reg_t  dispatch_rs1,
    input  phys_reg_t  dispatch_rs2,
    input  fu_result_t results [num_units],
    output logic       rs1_busy,
    output logic       rs2_busy
);

    // one bit per physical register, set while a write is pending
    logic [num_phys_regs-1:0] busy;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            busy <= '0;
        end else begin
            // results retire their destination
            for (int b = 0; b < num_units; b++) begin
                if (results[b].valid) begin
                    busy[results[b].tag] <= 1'b0;
                end
            end
            // new writer comes last so it wins over a result to the same register
            if (dispatch_accept) begin
                busy[dispatch_rd] <= 1'b1;
            end
        end
    end

    // stored state only, same-cycle results are matched in the entry array
    assign rs1_busy = busy[dispatch_rs1];
    assign rs2_busy = busy[dispatch_rs2];

endmodule

// File: verilog/dispatch_ctrl.sv
`timescale 1ns/1ps

module dispatch_ctrl import iq_pkg::*; #(
    parameter int num_entries = 8,
    parameter int num_units   = 3
) (
    input  logic                           clk,
    input  logic                           reset_n,
    input  logic                           dispatch_valid,
    input  logic [num_entries-1:0]         entry_valid,
    output logic                           dispatch_accept,
    output logic [$clog2(num_entries)-1:0] alloc_index,
    output unit_id_t                       alloc_unit,
    output logic                           iq_full
);

    localparam int idx_bits = $clog2(num_entries);

    logic     free_found;
    unit_id_t rr_unit;

    // priority search, lowest free slot first
    always_comb begin
        free_found  = 1'b0;
        alloc_index = '0;
        for (int i = 0; i < num_entries; i++) begin
            if (!entry_valid[i] && !free_found) begin
                free_found  = 1'b1;
                alloc_index = idx_bits'(i);
            end
        end
    end

    assign iq_full         = !free_found;
    assign dispatch_accept = dispatch_valid && !iq_full;

    // round robin over the units, only steps on an accepted dispatch
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rr_unit <= '0;
        end else if (dispatch_accept) begin
            if (rr_unit == unit_id_t'(num_units - 1)) begin
                rr_unit <= '0;
            end else begin
                rr_unit <= rr_unit + 1'b1;
            end
        end
    end

    assign alloc_unit = rr_unit;

endmodule

// File: verilog/iq_entry_array.sv
`timescale 1ns/1ps

module iq_entry_array import iq_pkg::*; #(
    parameter int num_entries = 8,
    parameter int num_units   = 3
) (
    input  logic                           clk,
    input  logic                           reset_n,
    input  logic                           dispatch_accept,
    input  logic [$clog2(num_entries)-1:0] alloc_index,
    input  unit_id_t                       alloc_unit,
    input  dispatch_t                      dispatch,
    input  logic                           rs1_busy,
    input  logic                           rs2_busy,
    input  fu_result_t                     results [num_units],
    input  logic [num_entries-1:0]         issue_clear,
    output iq_entry_t                      entries [num_entries],
    output logic [num_entries-1:0]         entry_valid,
    output logic [num_entries-1:0]         entry_ready
);

    logic [num_entries-1:0] rs1_ready;
    logic [num_entries-1:0] rs2_ready;

    // per-entry bus match, only acted on while the source still waits
    fu_result_t             rs1_hit [num_entries];
    fu_result_t             rs2_hit [num_entries];
    logic [num_entries-1:0] rs1_wake;
    logic [num_entries-1:0] rs2_wake;

    fu_result_t disp_rs1_hit;
    fu_result_t disp_rs2_hit;
    logic       disp_rs1_ready;
    logic       disp_rs2_ready;
    iq_entry_t  new_entry;

    // returns the matching bus, lowest numbered bus wins
    function automatic fu_result_t match_result(
        input phys_reg_t  tag,
        input fu_result_t res [num_units]
    );
        fu_result_t hit;
        hit = '0;
        for (int b = num_units - 1; b >= 0; b--) begin
            if (res[b].valid && res[b].tag == tag) begin
                hit = res[b];
            end
        end
        return hit;
    endfunction

    always_comb begin
        for (int i = 0; i < num_entries; i++) begin
            rs1_hit[i]  = match_result(entries[i].inst.rs1, results);
            rs2_hit[i]  = match_result(entries[i].inst.rs2, results);
            rs1_wake[i] = entry_valid[i] && !rs1_ready[i] && rs1_hit[i].valid;
            rs2_wake[i] = entry_valid[i] && !rs2_ready[i] && rs2_hit[i].valid;
        end
    end

    // a source is ready at dispatch if idle in the scoreboard or produced this cycle
    always_comb begin
        disp_rs1_hit   = match_result(dispatch.rs1, results);
        disp_rs2_hit   = match_result(dispatch.rs2, results);
        disp_rs1_ready = !rs1_busy || disp_rs1_hit.valid;
        disp_rs2_ready = !rs2_busy || disp_rs2_hit.valid;

        new_entry.inst = dispatch;
        new_entry.unit = alloc_unit;
        if (disp_rs1_hit.valid) begin
            new_entry.inst.rs1_val = disp_rs1_hit.value;
        end
        if (disp_rs2_hit.valid) begin
            new_entry.inst.rs2_val = disp_rs2_hit.value;
        end
    end

    // payload storage
    always_ff @(posedge clk) begin
        for (int i = 0; i < num_entries; i++) begin
            if (rs1_wake[i]) begin
                entries[i].inst.rs1_val <= rs1_hit[i].value;
            end
            if (rs2_wake[i]) begin
                entries[i].inst.rs2_val <= rs2_hit[i].value;
            end
        end
        // alloc slot is never valid, so it never overlaps a wake-up
        if (dispatch_accept) begin
            entries[alloc_index] <= new_entry;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            entry_valid <= '0;
            rs1_ready   <= '0;
            rs2_ready   <= '0;
        end else begin
            for (int i = 0; i < num_entries; i++) begin
                if (issue_clear[i]) begin
                    entry_valid[i] <= 1'b0;
                end
                if (rs1_wake[i]) begin
                    rs1_ready[i] <= 1'b1;
                end
                if (rs2_wake[i]) begin
                    rs2_ready[i] <= 1'b1;
                end
            end
            if (dispatch_accept) begin
                entry_valid[alloc_index] <= 1'b1;
                rs1_ready[alloc_index]   <= disp_rs1_ready;
                rs2_ready[alloc_index]   <= disp_rs2_ready;
            end
        end
    end

    assign entry_ready = entry_valid & rs1_ready & rs2_ready;

endmodule

// File: verilog/issue_select.sv
`timescale 1ns/1ps

module issue_select import iq_pkg::*; #(
    parameter int num_entries = 8,
    parameter int num_units   = 3
) (
    input  logic                   clk,
    input  logic                   reset_n,
    input  iq_entry_t              entries [num_entries],
    input  logic [num_entries-1:0] entry_ready,
    output logic [num_entries-1:0] issue_clear,
    output logic [num_units-1:0]   issue_valid,
    output iq_entry_t              issued [num_units]
);

    // one-hot pick per unit
    logic [num_entries-1:0] grant [num_units];
    iq_entry_t              pick  [num_units];
    logic [num_units-1:0]   picked;

    always_comb begin
        for (int u = 0; u < num_units; u++) begin
            grant[u] = '0;
            for (int i = 0; i < num_entries; i++) begin
                // lowest index ready entry that belongs to this unit
                if (entry_ready[i] && entries[i].unit == unit_id_t'(u) && grant[u] == '0) begin
                    grant[u][i] = 1'b1;
                end
            end
        end
    end

    // and-or mux, zero when nothing is granted
    always_comb begin
        for (int u = 0; u < num_units; u++) begin
            pick[u]   = '0;
            picked[u] = |grant[u];
            for (int i = 0; i < num_entries; i++) begin
                if (grant[u][i]) begin
                    pick[u] = pick[u] | entries[i];
                end
            end
        end
    end

    // fold unit grants into one per-entry clear mask
    always_comb begin
        issue_clear = '0;
        for (int u = 0; u < num_units; u++) begin
            issue_clear = issue_clear | grant[u];
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            issue_valid <= '0;
            for (int u = 0; u < num_units; u++) begin
                issued[u] <= '0;
            end
        end else begin
            issue_valid <= picked;
            for (int u = 0; u < num_units; u++) begin
                issued[u] <= pick[u];
            end
        end
    end

endmodule

// File: verilog/issue_queue.sv
`timescale 1ns/1ps

module issue_queue import iq_pkg::*; #(
    parameter int num_entries = 8,
    parameter int num_units   = 3
) (
    input  logic                 clk,
    input  logic                 reset_n,
    input  logic                 dispatch_valid,
    input  dispatch_t            dispatch,
    input  fu_result_t           results [num_units],
    output logic [num_units-1:0] issue_valid,
    output iq_entry_t            issued [num_units],
    output logic                 iq_full
);

    localparam int idx_bits = $clog2(num_entries);

    logic                   dispatch_accept;
    logic [idx_bits-1:0]    alloc_index;
    unit_id_t               alloc_unit;
    logic                   rs1_busy;
    logic                   rs2_busy;
    iq_entry_t              entries [num_entries];
    logic [num_entries-1:0] entry_valid;
    logic [num_entries-1:0] entry_ready;
    logic [num_entries-1:0] issue_clear;

    reg_scoreboard #(
        .num_units (num_units)
    ) reg_scoreboard_inst (
        .clk             (clk),
        .reset_n         (reset_n),
        .dispatch_accept (dispatch_accept),
        .dispatch_rd     (dispatch.rd),
        .dispatch_rs1    (dispatch.rs1),
        .dispatch_rs2    (dispatch.rs2),
        .results         (results),
        .rs1_busy        (rs1_busy),
        .rs2_busy        (rs2_busy)
    );

    dispatch_ctrl #(
        .num_entries (num_entries),
        .num_units   (num_units)
    ) dispatch_ctrl_inst (
        .clk             (clk),
        .reset_n         (reset_n),
        .dispatch_valid  (dispatch_valid),
        .entry_valid     (entry_valid),
        .dispatch_accept (dispatch_accept),
        .alloc_index     (alloc_index),
        .alloc_unit      (alloc_unit),
        .iq_full         (iq_full)
    );

    iq_entry_array #(
        .num_entries (num_entries),
        .num_units   (num_units)
    ) iq_entry_array_inst (
        .clk             (clk),
        .reset_n         (reset_n),
        .dispatch_accept (dispatch_accept),
        .alloc_index     (alloc_index),
        .alloc_unit      (alloc_unit),
        .dispatch        (dispatch),
        .rs1_busy        (rs1_busy),
        .rs2_busy        (rs2_busy),
        .results         (results),
        .issue_clear     (issue_clear),
        .entries         (entries),
        .entry_valid     (entry_valid),
        .entry_ready     (entry_ready)
    );

    issue_select #(
        .num_entries (num_entries),
        .num_units   (num_units)
    ) issue_select_inst (
        .clk         (clk),
        .reset_n     (reset_n),
        .entries     (entries),
        .entry_ready (entry_ready),
        .issue_clear (issue_clear),
        .issue_valid (issue_valid),
        .issued      (issued)
    );

endmodule

// File: test/issue_queue_sva.sv
`timescale 1ns/1ps

module issue_queue_sva import iq_pkg::*; #(
    parameter int num_units = 3
) (
    input logic                 clk,
    input logic                 reset_n,
    input logic [num_units-1:0] issue_valid,
    input iq_entry_t            issued [num_units]
);

    logic                 reset_fired = 1'b0;
    logic [num_units-1:0] port_fired;
    logic                 assert_fired;

    // nothing can be issued in the first cycle out of reset
    reset_quiet: assert property (@(posedge clk) $rose(reset_n) |-> issue_valid == '0)
        else begin
            $error("issue_valid set in the first cycle after reset");
            reset_fired = 1'b1;
        end

    for (genvar u = 0; u < num_units; u++) begin : g_port
        logic idle_fired = 1'b0;
        logic unit_fired = 1'b0;

        // idle port carries an all-zero payload
        idle_zero: assert property (
            @(posedge clk) disable iff (!reset_n) !issue_valid[u] |-> issued[u] == '0
        ) else begin
            $error("issue port %0d carries a payload while idle", u);
            idle_fired = 1'b1;
        end

        unit_match: assert property (
            @(posedge clk) disable iff (!reset_n) issue_valid[u] |-> issued[u].unit == unit_id_t'(u)
        ) else begin
            $error("issue port %0d carries an entry of unit %0d", u, issued[u].unit);
            unit_fired = 1'b1;
        end

        assign port_fired[u] = idle_fired | unit_fired;
    end

    assign assert_fired = reset_fired | (|port_fired);

endmodule

bind issue_queue issue_queue_sva #(
    .num_units (num_units)
) issue_queue_sva_inst (
    .clk         (clk),
    .reset_n     (reset_n),
    .issue_valid (issue_valid),
    .issued      (issued)
);

// File: test/tb_issue_queue.sv
`timescale 1ns/1ps

module tb_issue_queue import iq_pkg::*; ();

    localparam int num_entries = 8;
    localparam int num_units   = 3;
    localparam int num_robs    = 1 << rob_bits;
    // far above the length of the directed sequences
    localparam int max_cycles  = 400;

    logic                 clk;
    logic                 reset_n;
    logic                 dispatch_valid;
    dispatch_t            dispatch;
    fu_result_t           results [num_units];
    logic [num_units-1:0] issue_valid;
    iq_entry_t            issued [num_units];
    logic                 iq_full;

    // reference model keeps expected entries by rob index
    integer    seed;
    int        cycle_count = 0;
    int        outstanding = 0;
    int        next_rob    = 0;
    unit_id_t  exp_unit;
    logic      busy_model [num_phys_regs];
    iq_entry_t exp_by_rob [num_robs];
    logic      pending    [num_robs];
    logic      wait_rs1   [num_robs];
    logic      wait_rs2   [num_robs];
    dispatch_t d;

    issue_queue issue_queue_inst (
        .clk            (clk),
        .reset_n        (reset_n),
        .dispatch_valid (dispatch_valid),
        .dispatch       (dispatch),
        .results        (results),
        .issue_valid    (issue_valid),
        .issued         (issued),
        .iq_full        (iq_full)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic fail_now(input string what);
        $display("%s", what);
        $display("Checks failed");
        $fatal(1, "stopped at the first error");
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= max_cycles) begin
            fail_now($sformatf("Timeout, test still running after %0d cycles", cycle_count));
        end
        if (issue_queue_inst.issue_queue_sva_inst.assert_fired) begin
            fail_now("a bound assertion on the issue ports failed");
        end
    end

    task automatic make_inst(input int rd, input int rs1, input int rs2);
        d.funct3    = 3'($random(seed));
        d.funct7    = 7'($random(seed));
        d.opcode    = 7'($random(seed));
        d.rd        = phys_reg_t'(rd);
        d.rs1       = phys_reg_t'(rs1);
        d.rs1_val   = $random(seed);
        d.rs2       = phys_reg_t'(rs2);
        d.rs2_val   = $random(seed);
        d.immediate = $random(seed);
        d.rob_index = rob_bits'(next_rob);
        next_rob++;
    endtask

    // result frees its register and wakes waiting sources
    task automatic drive_result(input int bus, input int tag, input logic [xlen-1:0] value);
        results[bus].valid = 1'b1;
        results[bus].tag   = phys_reg_t'(tag);
        results[bus].value = value;
        busy_model[tag]    = 1'b0;
        for (int r = 0; r < num_robs; r++) begin
            if (pending[r] && wait_rs1[r] && exp_by_rob[r].inst.rs1 == phys_reg_t'(tag)) begin
                exp_by_rob[r].inst.rs1_val = value;
                wait_rs1[r] = 1'b0;
            end
            if (pending[r] && wait_rs2[r] && exp_by_rob[r].inst.rs2 == phys_reg_t'(tag)) begin
                exp_by_rob[r].inst.rs2_val = value;
                wait_rs2[r] = 1'b0;
            end
        end
    endtask

    // call after drive_result when both land on the same edge
    task automatic drive_dispatch(input logic taken);
        iq_entry_t e;
        logic      rs1_found;
        logic      rs2_found;
        e.inst = d;
        e.unit = exp_unit;
        rs1_found = 1'b0;
        rs2_found = 1'b0;
        dispatch_valid = 1'b1;
        dispatch       = d;
        if (taken) begin
            // a result on the same edge supplies the value, first matching bus
            for (int b = 0; b < num_units; b++) begin
                if (!rs1_found && results[b].valid && results[b].tag == d.rs1) begin
                    e.inst.rs1_val = results[b].value;
                    rs1_found      = 1'b1;
                end
                if (!rs2_found && results[b].valid && results[b].tag == d.rs2) begin
                    e.inst.rs2_val = results[b].value;
                    rs2_found      = 1'b1;
                end
            end
            wait_rs1[d.rob_index]   = busy_model[d.rs1] && !rs1_found;
            wait_rs2[d.rob_index]   = busy_model[d.rs2] && !rs2_found;
            exp_by_rob[d.rob_index] = e;
            pending[d.rob_index]    = 1'b1;
            outstanding++;
            busy_model[d.rd] = 1'b1;
            exp_unit = unit_id_t'((int'(exp_unit) + 1) % num_units);
        end
    endtask

    // one clock edge, then inputs back to idle and every issued payload checked
    task automatic step();
        int rob;
        @(posedge clk);
        #2;
        dispatch_valid = 1'b0;
        for (int b = 0; b < num_units; b++) begin
            results[b] = '0;
        end
        for (int u = 0; u < num_units; u++) begin
            if (issue_valid[u]) begin
                rob = issued[u].inst.rob_index;
                assert (pending[rob]) else
                    fail_now($sformatf("unit %0d issued rob %0d, which was never queued", u, rob));
                assert (!wait_rs1[rob] && !wait_rs2[rob]) else
                    fail_now($sformatf("rob %0d issued before its sources were ready", rob));
                assert (issued[u] == exp_by_rob[rob]) else
                    fail_now($sformatf("Mismatch at %0t: issued[%0d] expected %h, got %h",
                        $time, u, exp_by_rob[rob], issued[u]));
                pending[rob] = 1'b0;
                outstanding--;
            end
        end
    endtask

    task automatic expect_issue(input int rob);
        int u;
        u = exp_by_rob[rob].unit;
        assert (issue_valid[u] && issued[u].inst.rob_index == rob_bits'(rob)) else
            fail_now($sformatf(
                "Mismatch at %0t: issued[%0d].rob_index expected %0d, got %0d (valid %b)",
                $time, u, rob, issued[u].inst.rob_index, issue_valid[u]));
    endtask

    task automatic expect_idle();
        assert (issue_valid == '0) else
            fail_now($sformatf("Mismatch at %0t: issue_valid expected 0, got %b",
                $time, issue_valid));
    endtask

    task automatic check_full(input logic expected);
        assert (iq_full == expected) else
            fail_now($sformatf("Mismatch at %0t: iq_full expected %b, got %b",
                $time, expected, iq_full));
    endtask

    initial begin
        seed           = 29899;
        reset_n        = 1'b0;
        dispatch_valid = 1'b0;
        dispatch       = '0;
        exp_unit       = '0;
        for (int b = 0; b < num_units; b++) begin
            results[b] = '0;
        end
        for (int r = 0; r < num_phys_regs; r++) begin
            busy_model[r] = 1'b0;
        end
        for (int r = 0; r < num_robs; r++) begin
            pending[r]  = 1'b0;
            wait_rs1[r] = 1'b0;
            wait_rs2[r] = 1'b0;
        end
        repeat (5) @(posedge clk);
        #2;
        reset_n = 1'b1;

        expect_idle();
        check_full(1'b0);
        step();
        expect_idle();

        // independent instructions take the units in turn
        for (int k = 0; k < 3; k++) begin
            make_inst(1 + k, 10, 11);
            drive_dispatch(1'b1);
            step();
            if (k > 0) begin
                expect_issue(k - 1);
            end
        end
        step();
        expect_issue(2);

        // producer of r20 and a consumer that waits for its result
        make_inst(20, 10, 11);
        drive_dispatch(1'b1);
        step();
        make_inst(21, 20, 11);
        drive_dispatch(1'b1);
        step();
        expect_issue(3);
        repeat (3) begin
            step();
            expect_idle();
        end
        drive_result(0, 20, $random(seed));
        step();
        expect_idle();
        step();
        expect_issue(4);

        // r30 result on the same edge as a dispatch reading it as rs2
        make_inst(30, 10, 11);
        drive_dispatch(1'b1);
        step();
        step();
        expect_issue(5);
        make_inst(31, 10, 30);
        drive_result(1, 30, $random(seed));
        drive_dispatch(1'b1);
        step();
        step();
        expect_issue(6);

        // fill every slot behind r40 and drop one extra dispatch
        make_inst(40, 10, 11);
        drive_dispatch(1'b1);
        step();
        step();
        expect_issue(7);
        for (int k = 0; k < num_entries; k++) begin
            check_full(1'b0);
            make_inst(41 + k, 40, 11);
            drive_dispatch(1'b1);
            step();
        end
        check_full(1'b1);
        make_inst(50, 40, 11);
        drive_dispatch(1'b0);
        step();
        check_full(1'b1);
        drive_result(2, 40, $random(seed));
        step();
        while (outstanding > 0) begin
            step();
        end
        check_full(1'b0);
        repeat (4) begin
            step();
            expect_idle();
        end

        if (issue_queue_inst.issue_queue_sva_inst.assert_fired) begin
            fail_now("a bound assertion on the issue ports failed");
        end else begin
            $display("All checks passed");
            $finish;
        end
    end

endmodule

// File: sim.f
verilog/iq_pkg.sv
verilog/reg_scoreboard.sv
verilog/dispatch_ctrl.sv
verilog/iq_entry_array.sv
verilog/issue_select.sv
verilog/issue_queue.sv
test/issue_queue_sva.sv
test/tb_issue_queue.sv
